// File: verilog/cu_pkg.sv
package cu_pkg;

	typedef logic [2:0]  cycle_t;		// Encoded CPU cycle, 1 to 5 in use
	typedef logic [6:0]  opcode_t;		// Instruction opcode from the decoder
	typedef logic [4:0]  rnum_t;		// 0-7 regs, 8-15 constants, 16 temp
	typedef logic [15:0] psw_t;			// Processor status word
	typedef logic [6:0]  dbus_ctrl_t;	// [6] byte, [5:3] source, [2:0] destination
	typedef logic [5:0]  alu_op_t;		// ALU operation select
	typedef logic [3:0]  cond_t;		// Condition code, 0-14 named, 15 never

	// Branches, in condition table order
	localparam opcode_t OP_BEQ   = 7'd1;
	localparam opcode_t OP_BNE   = 7'd2;
	localparam opcode_t OP_BC    = 7'd3;
	localparam opcode_t OP_BNC   = 7'd4;
	localparam opcode_t OP_BN    = 7'd5;
	localparam opcode_t OP_BGE   = 7'd6;
	localparam opcode_t OP_BLT   = 7'd7;
	localparam opcode_t OP_BRA   = 7'd8;

	localparam opcode_t OP_ADD   = 7'd9;	// First of the two-operand ALU group
	localparam opcode_t OP_BIS   = 7'd20;	// Last of the two-operand ALU group
	localparam opcode_t OP_MOV   = 7'd21;
	localparam opcode_t OP_SRA   = 7'd23;
	localparam opcode_t OP_RRC   = 7'd24;
	localparam opcode_t OP_SETCC = 7'd30;
	localparam opcode_t OP_CLRCC = 7'd31;
	localparam opcode_t OP_CEX   = 7'd32;

	// PSW flag positions
	localparam int PSW_C   = 0;
	localparam int PSW_Z   = 1;
	localparam int PSW_N   = 2;
	localparam int PSW_SLP = 3;				// Sleep, halts fetch
	localparam int PSW_V   = 4;

	localparam psw_t PSW_RESET = 16'h60e0;	// Priority 7, flags clear

	localparam rnum_t RN_PC        = 5'd7;
	localparam rnum_t RN_CONST_TWO = 5'd10;	// Constant table entry holding 2

	// Source codes 0 MDR/MAR, 1 reg file, 2 IR, 3 ALU; same for destinations
	localparam dbus_ctrl_t DBUS_IDLE       = 7'b1111111;	// No valid route
	localparam dbus_ctrl_t DBUS_ALU_TO_REG = 7'b0011001;
	localparam dbus_ctrl_t DBUS_REG_TO_REG = 7'b0001001;
	localparam dbus_ctrl_t DBUS_MDR_TO_IR  = 7'b0000010;

	localparam dbus_ctrl_t ABUS_IDLE       = 7'b1111111;
	localparam dbus_ctrl_t ABUS_REG_TO_MAR = 7'b0001000;	// Reg file onto MAR

	localparam alu_op_t ALU_ADD = 6'd0;

endpackage

// File: verilog/cycle_sequencer.sv
`timescale 1ns/10ps

module cycle_sequencer #(
	parameter int ADDR_W = 16					// PC and breakpoint width
)
(
	input  logic              clock,
	input  logic              cpucycle_rst,
	input  logic              cycle_restart,	// From decoder, back to cycle 1
	input  logic [ADDR_W-1:0] pc,
	input  logic [ADDR_W-1:0] brkpnt,
	input  logic              sleep,			// PSW sleep bit
	input  logic              fetch_ack,
	output cu_pkg::cycle_t    cycle,
	output logic              fetch_req
);

	logic [4:0] step;				// One-hot, bit 0 is cycle 1
	logic       ack_seen;			// Ack has risen in this fetch
	logic       hold;				// Breakpoint hit or sleeping
	logic       fetch_done;			// Handshake closed, leave cycle 1

	assign hold       = (pc == brkpnt) || sleep;
	assign fetch_done = step[0] && ack_seen && !fetch_ack;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			step      <= 5'b00001;
			fetch_req <= 1'b0;
			ack_seen  <= 1'b0;
		end
		else
		begin
			if (cycle_restart)
				step <= 5'b00001;					// Instruction finished or skipped
			else if (fetch_done || !step[0])
				step <= {step[3:0], step[4]};		// Next cycle
			if (step[0])
			begin
				if (fetch_req && fetch_ack)
				begin
					fetch_req <= 1'b0;				// Ack seen, drop request
					ack_seen  <= 1'b1;
				end
				else if (!fetch_req && !ack_seen && !fetch_ack && !hold)
					fetch_req <= 1'b1;				// Start a fetch
				if (fetch_done)
					ack_seen <= 1'b0;				// Ready for the next fetch
			end
		end
	end

	// One-hot to binary cycle number
	assign cycle = {step[3] | step[4], step[1] | step[2], step[0] | step[2] | step[4]};

endmodule

// File: verilog/cex_unit.sv
`timescale 1ns/10ps

module cex_unit #(
	parameter int CEX_CNT_W = 3						// True and false count width
)
(
	input  logic                 clock,
	input  logic                 cpucycle_rst,
	input  cu_pkg::cycle_t       cycle,
	input  cu_pkg::cond_t        cond_sel,
	input  cu_pkg::psw_t         psw,
	input  logic                 cex_load,			// Capture a new window
	input  logic [CEX_CNT_W-1:0] t_cnt,
	input  logic [CEX_CNT_W-1:0] f_cnt,
	output logic                 cond_true,
	output logic                 decode_ok
);
	import cu_pkg::*;

	logic                 active;			// Window in progress
	logic                 result;			// Condition captured at CEX
	logic [CEX_CNT_W-1:0] t_left;
	logic [CEX_CNT_W-1:0] f_left;
	logic [CEX_CNT_W-1:0] t_next;
	logic [CEX_CNT_W-1:0] f_next;
	logic                 c, z, n, v;

	assign c = psw[PSW_C];
	assign z = psw[PSW_Z];
	assign n = psw[PSW_N];
	assign v = psw[PSW_V];

	always_comb
	begin
		case (cond_sel)
			4'd0:    cond_true = z;					// EQ
			4'd1:    cond_true = !z;				// NE
			4'd2:    cond_true = c;					// CS
			4'd3:    cond_true = !c;				// CC
			4'd4:    cond_true = n;					// MI
			4'd5:    cond_true = !n;				// PL
			4'd6:    cond_true = v;					// VS
			4'd7:    cond_true = !v;				// VC
			4'd8:    cond_true = c && !z;			// HI
			4'd9:    cond_true = !c || z;			// LS
			4'd10:   cond_true = (n == v);			// GE
			4'd11:   cond_true = (n != v);			// LT
			4'd12:   cond_true = !z && (n == v);	// GT
			4'd13:   cond_true = z || (n != v);		// LE
			4'd14:   cond_true = 1'b1;				// AL
			default: cond_true = 1'b0;				// Never
		endcase
	end

	// True count runs down first, then the false count
	assign t_next = (t_left != '0) ? t_left - 1'b1 : t_left;
	assign f_next = ((t_left == '0) && (f_left != '0)) ? f_left - 1'b1 : f_left;

	assign decode_ok = (cycle == cycle_t'(4)) && (!active ||
		(result && (t_left != '0)) ||
		(!result && (t_left == '0) && (f_left != '0)));

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active <= 1'b0;
			result <= 1'b0;
			t_left <= '0;
			f_left <= '0;
		end
		else if (cex_load)
		begin
			active <= 1'b1;					// Open the window
			result <= cond_true;
			t_left <= t_cnt;
			f_left <= f_cnt;
		end
		else if ((cycle == cycle_t'(4)) && active)
		begin
			t_left <= t_next;
			f_left <= f_next;
			if ((t_next == '0) && (f_next == '0))
				active <= 1'b0;				// Window used up
		end
	end

endmodule

// File: verilog/psw_reg.sv
`timescale 1ns/10ps

module psw_reg
(
	input  logic         clock,
	input  logic         cpucycle_rst,
	input  logic [4:0]   alu_flags,			// V, SLP, N, Z, C from the ALU
	input  logic         alu_flags_valid,	// One-cycle load strobe
	input  logic         psw_set,			// SETCC
	input  logic         psw_clr,			// CLRCC
	input  logic [4:0]   pswb,				// Flag mask
	output cu_pkg::psw_t psw
);
	import cu_pkg::*;

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			psw <= PSW_RESET;
		else if (alu_flags_valid)
			psw[4:0] <= alu_flags;				// ALU wins over SETCC and CLRCC
		else if (psw_set)
			psw[4:0] <= psw[4:0] | pswb;
		else if (psw_clr)
			psw[4:0] <= psw[4:0] & ~pswb;
	end

endmodule

// File: verilog/exec_decoder.sv
`timescale 1ns/10ps

module exec_decoder
(
	input  cu_pkg::cycle_t     cycle,
	input  cu_pkg::opcode_t    op,
	input  logic [2:0]         dst,
	input  logic [2:0]         srccon,		// Source register or constant
	input  logic               rc,			// 1 selects the constant table
	input  logic               wb,			// 1 byte, 0 word
	input  cu_pkg::cond_t      cond,		// CEX condition field
	input  logic [4:0]         pswb_in,		// SETCC and CLRCC mask field
	input  logic               cond_true,
	input  logic               decode_ok,
	output logic               alu_en,
	output logic               id_en,
	output cu_pkg::dbus_ctrl_t data_bus_ctrl,
	output cu_pkg::dbus_ctrl_t addr_bus_ctrl,
	output cu_pkg::alu_op_t    alu_op,
	output cu_pkg::rnum_t      alu_rnum_dst,
	output cu_pkg::rnum_t      alu_rnum_src,
	output cu_pkg::rnum_t      dbus_rnum_dst,
	output cu_pkg::rnum_t      dbus_rnum_src,
	output logic               psw_update,
	output logic               cycle_restart,
	output cu_pkg::cond_t      cond_sel,
	output logic               cex_load,
	output logic               psw_set,
	output logic               psw_clr,
	output logic [4:0]         pswb
);
	import cu_pkg::*;

	opcode_t alu_base;		// Opcode offset into the ALU operation table

	assign alu_base = (op >= OP_SRA) ? op - 7'd11 : op - OP_ADD;

	always_comb
	begin
		alu_en        = 1'b0;
		id_en         = 1'b0;
		data_bus_ctrl = DBUS_IDLE;
		addr_bus_ctrl = ABUS_IDLE;
		alu_op        = ALU_ADD;
		alu_rnum_dst  = '0;
		alu_rnum_src  = '0;
		dbus_rnum_dst = '0;
		dbus_rnum_src = '0;
		psw_update    = 1'b0;
		cycle_restart = 1'b0;
		cond_sel      = 4'd15;					// Never
		cex_load      = 1'b0;
		psw_set       = 1'b0;
		psw_clr       = 1'b0;
		pswb          = '0;
		case (cycle)
			3'd1:	// Fetch, PC to MAR and set up PC plus two
			begin
				addr_bus_ctrl = ABUS_REG_TO_MAR;
				dbus_rnum_src = RN_PC;
				alu_rnum_dst  = RN_PC;
				alu_rnum_src  = RN_CONST_TWO;
			end
			3'd2:	// PC plus two written back
			begin
				alu_en        = 1'b1;
				data_bus_ctrl = DBUS_ALU_TO_REG;
				dbus_rnum_dst = RN_PC;
			end
			3'd3:
				data_bus_ctrl = DBUS_MDR_TO_IR;	// Instruction into IR
			3'd4:	// Decode unless CEX skips it
			begin
				id_en         = decode_ok;
				cycle_restart = !decode_ok;
			end
			3'd5:	// Execute
			begin
				cycle_restart = 1'b1;
				case (op)
					OP_BEQ, OP_BNE, OP_BC, OP_BNC, OP_BN, OP_BGE, OP_BLT, OP_BRA:
					begin
						cond_sel = (op <= OP_BN) ? cond_t'(op - 7'd1) : cond_t'(op + 7'd4);
						if (cond_true)
						begin
							alu_en        = 1'b1;			// PC plus extended offset
							alu_rnum_dst  = RN_PC;
							dbus_rnum_dst = RN_PC;
							data_bus_ctrl = DBUS_ALU_TO_REG;
						end
					end
					OP_ADD, 7'd10, 7'd11, 7'd12, 7'd13, 7'd14, 7'd15, 7'd16, 7'd17,
					7'd18, 7'd19, OP_BIS, OP_SRA, OP_RRC:
					begin
						alu_en        = 1'b1;
						alu_op        = {alu_base[4:0], wb};	// Word and byte pairs
						alu_rnum_dst  = {2'b00, dst};
						alu_rnum_src  = {1'b0, rc, srccon};	// Plus 8 for constants
						dbus_rnum_dst = {2'b00, dst};
						data_bus_ctrl = {wb, DBUS_ALU_TO_REG[5:0]};
						psw_update    = 1'b1;
					end
					OP_MOV:
					begin
						dbus_rnum_dst = {2'b00, dst};
						dbus_rnum_src = {2'b00, srccon};
						data_bus_ctrl = DBUS_REG_TO_REG;
					end
					OP_SETCC:
					begin
						psw_set = 1'b1;
						pswb    = pswb_in;
					end
					OP_CLRCC:
					begin
						psw_clr = 1'b1;
						pswb    = pswb_in;
					end
					OP_CEX:
					begin
						cond_sel = cond;
						cex_load = 1'b1;				// Open the window
					end
					default: ;							// Unknown, restart only
				endcase
			end
			default:
				cycle_restart = 1'b1;
		endcase
	end

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/10ps

module control_unit #(
	parameter int ADDR_W    = 16,
	parameter int CEX_CNT_W = 3
)
(
	input  logic                 clock,
	input  logic                 cpucycle_rst,
	input  logic [ADDR_W-1:0]    pc,
	input  logic [ADDR_W-1:0]    brkpnt,
	input  logic                 fetch_ack,
	input  cu_pkg::opcode_t      op,
	input  logic [2:0]           dst,
	input  logic [2:0]           srccon,
	input  logic                 rc,
	input  logic                 wb,
	input  cu_pkg::cond_t        cond,
	input  logic [CEX_CNT_W-1:0] t_cnt,
	input  logic [CEX_CNT_W-1:0] f_cnt,
	input  logic [4:0]           pswb,
	input  logic [4:0]           alu_flags,
	input  logic                 alu_flags_valid,
	output logic                 fetch_req,
	output cu_pkg::cycle_t       cycle,
	output cu_pkg::psw_t         psw_out,
	output logic                 alu_en,
	output logic                 id_en,
	output cu_pkg::dbus_ctrl_t   data_bus_ctrl,
	output cu_pkg::dbus_ctrl_t   addr_bus_ctrl,
	output cu_pkg::alu_op_t      alu_op,
	output cu_pkg::rnum_t        alu_rnum_dst,
	output cu_pkg::rnum_t        alu_rnum_src,
	output cu_pkg::rnum_t        dbus_rnum_dst,
	output cu_pkg::rnum_t        dbus_rnum_src,
	output logic                 psw_update
);
	import cu_pkg::*;

	psw_t       psw;
	logic       cycle_restart;
	cond_t      cond_sel;
	logic       cex_load;
	logic       psw_set;
	logic       psw_clr;
	logic [4:0] dec_pswb;		// Mask gated to SETCC and CLRCC
	logic       cond_true;
	logic       decode_ok;

	assign psw_out = psw;

	cycle_sequencer #(.ADDR_W(ADDR_W)) u_seq (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .cycle_restart(cycle_restart),
		.pc(pc), .brkpnt(brkpnt), .sleep(psw[PSW_SLP]), .fetch_ack(fetch_ack),
		.cycle(cycle), .fetch_req(fetch_req));

	cex_unit #(.CEX_CNT_W(CEX_CNT_W)) u_cex (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .cycle(cycle), .cond_sel(cond_sel),
		.psw(psw), .cex_load(cex_load), .t_cnt(t_cnt), .f_cnt(f_cnt),
		.cond_true(cond_true), .decode_ok(decode_ok));

	psw_reg u_psw (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .alu_flags(alu_flags),
		.alu_flags_valid(alu_flags_valid), .psw_set(psw_set), .psw_clr(psw_clr),
		.pswb(dec_pswb), .psw(psw));

	exec_decoder u_dec (
		.cycle(cycle), .op(op), .dst(dst), .srccon(srccon), .rc(rc), .wb(wb),
		.cond(cond), .pswb_in(pswb), .cond_true(cond_true), .decode_ok(decode_ok),
		.alu_en(alu_en), .id_en(id_en), .data_bus_ctrl(data_bus_ctrl),
		.addr_bus_ctrl(addr_bus_ctrl), .alu_op(alu_op), .alu_rnum_dst(alu_rnum_dst),
		.alu_rnum_src(alu_rnum_src), .dbus_rnum_dst(dbus_rnum_dst),
		.dbus_rnum_src(dbus_rnum_src), .psw_update(psw_update),
		.cycle_restart(cycle_restart), .cond_sel(cond_sel), .cex_load(cex_load),
		.psw_set(psw_set), .psw_clr(psw_clr), .pswb(dec_pswb));

endmodule

// File: tb/control_unit_chk.sv
`timescale 1ns/10ps

module control_unit_chk
(
	input logic       clock,
	input logic       cpucycle_rst,
	input logic       fetch_req,
	input logic       fetch_ack,
	input logic [2:0] cycle
);

	int fails = 0;		// Failed assertions so far

	// Request drops only after memory has acked
	req_held_for_ack: assert property (@(posedge clock) disable iff (cpucycle_rst)
		$fell(fetch_req) |-> $past(fetch_ack))
	else
	begin
		$error("fetch_req fell before fetch_ack rose");
		fails++;
	end

	// New request only once the previous ack is gone
	no_req_during_ack: assert property (@(posedge clock) disable iff (cpucycle_rst)
		$rose(fetch_req) |-> !$past(fetch_ack))
	else
	begin
		$error("fetch_req rose while fetch_ack was high");
		fails++;
	end

	// Cycle register holds at 1 for the whole handshake
	cycle_held_in_fetch: assert property (@(posedge clock) disable iff (cpucycle_rst)
		(fetch_req || fetch_ack) |-> (cycle == 3'd1))
	else
	begin
		$error("cycle left 1 during the fetch handshake");
		fails++;
	end

endmodule

bind control_unit control_unit_chk u_chk (
	.clock(clock), .cpucycle_rst(cpucycle_rst), .fetch_req(fetch_req),
	.fetch_ack(fetch_ack), .cycle(cycle));

// File: tb/control_unit_tb.sv
`timescale 1ns/10ps

module control_unit_tb;
	import cu_pkg::*;

	typedef struct packed {
		logic       alu_en;
		logic       id_en;
		logic [6:0] dbus;
		logic [6:0] abus;
		logic [5:0] alu_op;
		logic [4:0] ard;
		logic [4:0] ars;
		logic [4:0] drd;
		logic [4:0] drs;
		logic       psw_upd;
	} ctrl_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic        restart;
		logic [15:0] psw_nx;		// Model PSW after this clock
		logic        act_nx;		// Model CEX window after this clock
		logic        res_nx;
		logic [2:0]  t_nx;
		logic [2:0]  f_nx;
	} ref_t;

	logic clock, cpucycle_rst, fetch_ack, rc, wb, alu_flags_valid, fetch_req;
	logic [15:0] pc, brkpnt, psw_out;
	logic [6:0] op, data_bus_ctrl, addr_bus_ctrl;
	logic [2:0] dst, srccon, t_cnt, f_cnt, cycle;
	logic [3:0] cond;
	logic [4:0] pswb, alu_flags, alu_rnum_dst, alu_rnum_src, dbus_rnum_dst, dbus_rnum_src;
	logic [5:0] alu_op;
	logic alu_en, id_en, psw_update;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int instr_count = 0;
	logic [15:0] lfsr_state = 16'd48;
	logic acked = 0;					// Memory closed the handshake
	logic [6:0] override_op = 0;		// Forced next opcode when nonzero
	logic [4:0] override_pswb = 0;

	control_unit #(.ADDR_W(16), .CEX_CNT_W(3)) UUT (.*);

	always #4 clock = !clock;			// 8 ns period

	// Galois LFSR, one step per bit taken
	function automatic int rand_bits(input int n);
		int v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | lfsr_state[0];
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hb400 : lfsr_state >> 1;
		end
		return v;
	endfunction

	function automatic logic cond_eval(input logic [3:0] code, input logic [15:0] p);
		logic c, z, n, v;
		c = p[0];
		z = p[1];
		n = p[2];
		v = p[4];
		case (code)
			0: return z;
			1: return !z;
			2: return c;
			3: return !c;
			4: return n;
			5: return !n;
			6: return v;
			7: return !v;
			8: return c && !z;
			9: return !c || z;
			10: return n == v;
			11: return n != v;
			12: return !z && (n == v);
			13: return z || (n != v);
			14: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Expected control word and next model state for one clock
	function automatic ref_t ref_model(input logic [2:0] cyc, input logic [6:0] o,
		input logic [15:0] p, input logic act, input logic res, input logic [2:0] t,
		input logic [2:0] f);
		ref_t r;
		logic dok;
		r = '0;
		r.ctrl.dbus = DBUS_IDLE;
		r.ctrl.abus = ABUS_IDLE;
		r.psw_nx = p;
		r.act_nx = act;
		r.res_nx = res;
		r.t_nx = t;
		r.f_nx = f;
		dok = !act || (res && t != 0) || (!res && t == 0 && f != 0);
		case (cyc)
			1:
			begin
				r.ctrl.abus = ABUS_REG_TO_MAR;				// PC to MAR
				r.ctrl.drs = RN_PC;
				r.ctrl.ard = RN_PC;
				r.ctrl.ars = RN_CONST_TWO;
			end
			2:
			begin
				r.ctrl.alu_en = 1;
				r.ctrl.dbus = DBUS_ALU_TO_REG;
				r.ctrl.drd = RN_PC;
			end
			3: r.ctrl.dbus = DBUS_MDR_TO_IR;
			4:
			begin
				r.ctrl.id_en = dok;
				r.restart = !dok;
				if (act)
				begin
					r.t_nx = (t != 0) ? t - 1 : t;			// True count first
					r.f_nx = (t == 0 && f != 0) ? f - 1 : f;
					r.act_nx = (r.t_nx != 0) || (r.f_nx != 0);
				end
			end
			5:
			begin
				r.restart = 1;
				if (o >= 1 && o <= 8)
				begin
					if (cond_eval((o <= 5) ? o - 1 : o + 4, p))
					begin
						r.ctrl.alu_en = 1;					// PC plus offset
						r.ctrl.ard = RN_PC;
						r.ctrl.drd = RN_PC;
						r.ctrl.dbus = DBUS_ALU_TO_REG;
					end
				end
				else if ((o >= 9 && o <= 20) || o == 23 || o == 24)
				begin
					r.ctrl.alu_en = 1;
					r.ctrl.alu_op = 2 * (o - ((o >= 23) ? 11 : 9)) + wb;
					r.ctrl.ard = dst;
					r.ctrl.drd = dst;
					r.ctrl.ars = srccon + 8 * rc;
					r.ctrl.dbus = {wb, DBUS_ALU_TO_REG[5:0]};
					r.ctrl.psw_upd = 1;
				end
				else if (o == OP_MOV)
				begin
					r.ctrl.drd = dst;
					r.ctrl.drs = srccon;
					r.ctrl.dbus = DBUS_REG_TO_REG;
				end
				else if (o == OP_CEX)
				begin
					r.act_nx = 1;
					r.res_nx = cond_eval(cond, p);
					r.t_nx = t_cnt;
					r.f_nx = f_cnt;
				end
			end
			default: ;
		endcase
		if (alu_flags_valid)
			r.psw_nx[4:0] = alu_flags;					// ALU load wins
		else if (cyc == 5 && o == OP_SETCC)
			r.psw_nx[4:0] = p[4:0] | pswb;
		else if (cyc == 5 && o == OP_CLRCC)
			r.psw_nx[4:0] = p[4:0] & ~pswb;
		return r;
	endfunction

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok === 1'b1) else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	task automatic finish_run();
		$display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, UUT.u_chk.fails);
		if (errors == 0 && timeouts == 0 && UUT.u_chk.fails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	task automatic timed_out(input string what);
		timeouts++;
		$display("Timeout while waiting for %s", what);
		finish_run();
	endtask

	// Compare process, samples at the rising edge
	initial
	begin
		ref_t r;
		ctrl_t got;
		logic [15:0] m_psw;
		logic [2:0] exp_cyc, m_t, m_f;
		logic m_act, m_res;
		forever
		begin
			@(posedge clock);
			if (cpucycle_rst)
			begin
				m_psw = PSW_RESET;
				{m_act, m_res, m_t, m_f} = '0;
				exp_cyc = 1;
			end
			else
			begin
				got = {alu_en, id_en, data_bus_ctrl, addr_bus_ctrl, alu_op, alu_rnum_dst,
					alu_rnum_src, dbus_rnum_dst, dbus_rnum_src, psw_update};
				r = ref_model(exp_cyc, op, m_psw, m_act, m_res, m_t, m_f);
				check(cycle == exp_cyc, $sformatf("cycle exp %0d got %0d", exp_cyc, cycle));
				check(psw_out == m_psw, $sformatf("psw exp %h got %h", m_psw, psw_out));
				check(got == r.ctrl, $sformatf("cycle %0d op %0d control exp %h got %h",
					exp_cyc, op, r.ctrl, got));
				if (exp_cyc == 1)
					exp_cyc = (acked && !fetch_ack) ? 3'd2 : 3'd1;	// Handshake closed
				else
					exp_cyc = r.restart ? 3'd1 : exp_cyc + 3'd1;
				if (exp_cyc == 2)
					acked = 0;
				m_psw = r.psw_nx;
				{m_act, m_res, m_t, m_f} = {r.act_nx, r.res_nx, r.t_nx, r.f_nx};
			end
		end
	end

	// Instruction memory, four-phase handshake with random latency
	initial
	begin
		int n, d;
		forever
		begin
			n = 0;
			do
			begin
				@(negedge clock);
				n++;
				if (n > 200)
					timed_out("fetch_req to rise");
			end
			while (!fetch_req);
			d = rand_bits(3) % 6;
			repeat (d) @(negedge clock);
			op = (override_op != 0) ? override_op : rand_bits(6) % 36;
			pswb = (override_op != 0) ? override_pswb : rand_bits(5) & 5'b10111;
			{dst, srccon, rc, wb, cond, t_cnt, f_cnt} = rand_bits(18);
			fetch_ack = 1;
			n = 0;
			do
			begin
				@(negedge clock);
				n++;
				if (n > 50)
					timed_out("fetch_req to fall");
			end
			while (fetch_req);
			fetch_ack = 0;
			acked = 1;
			instr_count++;
		end
	end

	initial
	begin
		int n;
		{clock, fetch_ack, op, dst, srccon, rc, wb, cond, t_cnt, f_cnt, pswb} = '0;
		{alu_flags, alu_flags_valid} = '0;
		pc = 16'h0100;
		brkpnt = 16'hffff;
		cpucycle_rst = 1;
		repeat (8) @(negedge clock);
		cpucycle_rst = 0;
		#1;
		check(cycle == 1 && psw_out == PSW_RESET && !alu_en && !id_en && !psw_update
			&& data_bus_ctrl == DBUS_IDLE && !fetch_req, "reset state");
		@(posedge clock);
		#1;
		check(fetch_req, "fetch_req one clock after reset");
		n = 0;
		while (instr_count < 300)
		begin
			@(negedge clock);
			alu_flags_valid = (rand_bits(3) == 0);		// Occasional flag strobe
			alu_flags = rand_bits(5) & 5'b10111;		// Sleep bit stays clear
			n++;
			if (n > 20000)
				timed_out("random instructions");
		end
		alu_flags_valid = 0;
		n = 0;
		do
		begin
			@(negedge clock);
			n++;
			if (n > 200)
				timed_out("cycle 5 before breakpoint");
		end
		while (cycle != 5);
		brkpnt = pc;
		override_op = OP_SETCC;
		override_pswb = 5'b01000;						// Sleep bit
		repeat (20)
		begin
			@(negedge clock);
			check(!fetch_req && cycle == 1, "breakpoint hold");
		end
		pc = pc + 2;
		n = 0;
		do
		begin
			@(negedge clock);
			n++;
			if (n > 200)
				timed_out("sleep bit after SETCC");
		end
		while (!psw_out[PSW_SLP]);
		repeat (20)
		begin
			@(negedge clock);
			check(!fetch_req && cycle == 1, "fetch stopped in sleep");
		end
		finish_run();
	end

endmodule

// File: sim.f
verilog/cu_pkg.sv
verilog/cycle_sequencer.sv
verilog/cex_unit.sv
verilog/psw_reg.sv
verilog/exec_decoder.sv
verilog/control_unit.sv
tb/control_unit_chk.sv
tb/control_unit_tb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - verilog/cu_pkg.sv
  - verilog/cycle_sequencer.sv
  - verilog/cex_unit.sv
  - verilog/psw_reg.sv
  - verilog/exec_decoder.sv
  - verilog/control_unit.sv
  - target: test
    files:
      - tb/control_unit_chk.sv
      - tb/control_unit_tb.sv
